// ==== dsp_pkg.sv ====
package dsp_pkg;

  typedef logic [15:0] word_t;
  typedef logic [7:0]  byte_t;
  typedef logic [23:0] insn_t;

  typedef enum logic [1:0] {
    I_OP = 2'b00,
    I_RT = 2'b01,
    I_JP = 2'b10,
    I_LD = 2'b11
  } insn_class_e;

  // one-hot, one instruction every eight cycles
  typedef enum logic [7:0] {
    ST_FETCH = 8'b0000_0001,
    ST_LOAD  = 8'b0000_0010,
    ST_ALU1  = 8'b0000_0100,
    ST_ALU2  = 8'b0000_1000,
    ST_STORE = 8'b0001_0000,
    ST_NEXT  = 8'b0010_0000,
    ST_IDLE1 = 8'b0100_0000,
    ST_IDLE2 = 8'b1000_0000
  } exec_state_e;

  typedef enum logic [3:0] {
    FN_NOP, FN_OR, FN_AND, FN_XOR, FN_SUB, FN_ADD, FN_SBB, FN_ADC,
    FN_DEC, FN_INC, FN_CMP, FN_SHR1, FN_SHL1, FN_SHL2, FN_SHL4, FN_XCHG
  } alu_fn_e;

  typedef enum logic [1:0] {
    P_RAM = 2'b00,
    P_IDB = 2'b01,
    P_M   = 2'b10,
    P_N   = 2'b11
  } p_sel_e;

  // source and destination share this code table
  typedef enum logic [3:0] {
    REG_NON = 4'h0,
    REG_ACA = 4'h1,
    REG_ACB = 4'h2,
    REG_TR  = 4'h3,
    REG_DR  = 4'h6,
    REG_SR  = 4'h7,
    REG_TRB = 4'he
  } reg_sel_e;

  typedef struct packed {
    logic s1;
    logic s0;
    logic c;
    logic z;
    logic ov1;
    logic ov0;
  } flags_t;

  typedef struct packed {
    alu_fn_e fn;
    logic    acc;     // 0 = A, 1 = B
    p_sel_e  p_sel;
    logic    active;  // OP or RT
  } alu_ctl_t;

  typedef struct packed {
    logic  cs_n;
    logic  rd_n;
    logic  wr_n;
    logic  a0;
    byte_t di;
  } host_bus_t;

  typedef struct packed {
    logic        wr;
    logic [10:0] addr;
    insn_t       data;
  } pgm_load_t;

  localparam int SR_RQM = 15;
  localparam int SR_DRS = 12;
  localparam int SR_DRC = 10;

  // bits 14 13 11 10 9 8 7 1 0
  localparam word_t SR_USER_MASK = 16'h6f83;

endpackage

// ==== dsp_program_rom.sv ====
`timescale 1ns/10ps

module dsp_program_rom #(
  parameter int PGM_ADDR_W = 11
) (
  input  logic                  CLK,
  input  dsp_pkg::pgm_load_t    load,
  input  logic [PGM_ADDR_W-1:0] rd_addr,
  output dsp_pkg::insn_t        rd_data
);
  import dsp_pkg::*;

  insn_t mem [2**PGM_ADDR_W];

  // write port from the loader
  always_ff @(posedge CLK) begin
    if (load.wr) begin
      mem[PGM_ADDR_W'(load.addr)] <= load.data;
    end
  end

  // read port, one cycle latency
  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== dsp_host_port.sv ====
`timescale 1ns/10ps

module dsp_host_port (
  input  logic               CLK,
  input  logic               RST,
  input  dsp_pkg::host_bus_t bus,
  output dsp_pkg::byte_t     do_byte,
  input  logic               dr_load,
  input  logic               sr_load,
  input  logic               rqm_set,
  input  dsp_pkg::word_t     dr_in,
  input  dsp_pkg::word_t     sr_in,
  output dsp_pkg::word_t     dr,
  output dsp_pkg::word_t     sr
);
  import dsp_pkg::*;

  logic [5:0] rd_sreg;
  logic [5:0] wr_sreg;
  logic [2:0] cs_sreg;  // only sampled three back
  logic [2:0] a0_sreg;
  logic       rd_rise;
  logic       wr_rise;
  logic       data_acc;
  logic       wr_data;
  logic       rqm;
  logic       drs;
  logic       drc;
  word_t      sr_user;

  //////////////////////////////////////////////////////////////////////
  // strobe synchronizers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_sreg <= '1;
      wr_sreg <= '1;
      cs_sreg <= '1;
      a0_sreg <= '1;
    end else begin
      rd_sreg <= {rd_sreg[4:0], bus.rd_n};
      wr_sreg <= {wr_sreg[4:0], bus.wr_n};
      cs_sreg <= {cs_sreg[1:0], bus.cs_n};
      a0_sreg <= {a0_sreg[1:0], bus.a0};
    end
  end

  // five lows then a high
  assign rd_rise  = !cs_sreg[2] && (rd_sreg == 6'b000001);
  assign wr_rise  = !cs_sreg[2] && (wr_sreg == 6'b000001);
  assign data_acc = (rd_rise || wr_rise) && !a0_sreg[2];
  assign wr_data  = wr_rise && !a0_sreg[2];

  assign drc = sr_user[SR_DRC];

  //////////////////////////////////////////////////////////////////////
  // status bits and data register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RST) begin
      rqm     <= 1'b0;
      drs     <= 1'b0;
      sr_user <= '0;
    end else begin
      if (sr_load) sr_user <= sr_in & SR_USER_MASK;
      if (rqm_set) begin
        rqm <= 1'b1;
      end else if (data_acc && (drc || drs)) begin
        rqm <= 1'b0;  // last byte of the word
      end
      if (data_acc && !drc) drs <= ~drs;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      dr <= '0;
    end else if (wr_data) begin
      if (!drc && drs) dr[15:8] <= bus.di;
      else dr[7:0] <= bus.di;
    end else if (dr_load) begin
      dr <= dr_in;
    end
  end

  always_comb begin
    sr         = sr_user;
    sr[SR_RQM] = rqm;
    sr[SR_DRS] = drs;
  end

  // host read mux
  always_comb begin
    if (bus.a0) begin
      do_byte = sr[15:8];
    end else if (drc || !drs) begin
      do_byte = dr[7:0];
    end else begin
      do_byte = dr[15:8];
    end
  end

endmodule

// ==== dsp_alu.sv ====
`timescale 1ns/10ps

module dsp_alu (
  input  logic                 CLK,
  input  logic                 RST,
  input  dsp_pkg::exec_state_e state,
  input  dsp_pkg::alu_ctl_t    ctl,
  input  dsp_pkg::word_t       idb,
  input  logic                 acc_wr_a,
  input  logic                 acc_wr_b,
  output dsp_pkg::word_t       acc_a,
  output dsp_pkg::word_t       acc_b,
  output dsp_pkg::flags_t      flags_a,
  output dsp_pkg::flags_t      flags_b
);
  import dsp_pkg::*;

  word_t  alu_p;
  word_t  alu_q;
  word_t  alu_r;
  word_t  acc_reg [2];
  flags_t fl [2];
  flags_t fl_nx;
  logic   cin;
  logic   ovf;
  logic   r_skip;  // bus move already wrote the target

  assign cin = fl[~ctl.acc].c;  // carry from the other accumulator

  //////////////////////////////////////////////////////////////////////
  // operand and result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == ST_ALU1 && ctl.active) begin
      alu_q <= acc_reg[ctl.acc];
      if (ctl.fn inside {FN_DEC, FN_INC}) begin
        alu_p <= 16'h0001;
      end else if (ctl.p_sel == P_IDB) begin
        alu_p <= idb;
      end else begin
        alu_p <= '0;  // no ram, m, n here
      end
    end
    if (state == ST_ALU2 && ctl.active) begin
      case (ctl.fn)
        FN_OR:   alu_r <= alu_q | alu_p;
        FN_AND:  alu_r <= alu_q & alu_p;
        FN_XOR:  alu_r <= alu_q ^ alu_p;
        FN_SUB:  alu_r <= alu_q - alu_p;
        FN_ADD:  alu_r <= alu_q + alu_p;
        FN_SBB:  alu_r <= alu_q - alu_p - word_t'(cin);
        FN_ADC:  alu_r <= alu_q + alu_p + word_t'(cin);
        FN_DEC:  alu_r <= alu_q - alu_p;
        FN_INC:  alu_r <= alu_q + alu_p;
        FN_CMP:  alu_r <= ~alu_q;
        FN_SHR1: alu_r <= {alu_q[15], alu_q[15:1]};
        FN_SHL1: alu_r <= {alu_q[14:0], cin};
        FN_SHL2: alu_r <= {alu_q[13:0], 2'b11};
        FN_SHL4: alu_r <= {alu_q[11:0], 4'hf};
        FN_XCHG: alu_r <= {alu_q[7:0], alu_q[15:8]};
        default: alu_r <= alu_q;
      endcase
    end
  end

  // next flags for the selected accumulator
  always_comb begin
    fl_nx = fl[ctl.acc];
    ovf   = 1'b0;
    if (ctl.fn != FN_NOP) begin
      fl_nx.z  = (alu_r == '0);
      fl_nx.s0 = alu_r[15];
    end
    case (ctl.fn)
      FN_OR, FN_AND, FN_XOR, FN_CMP, FN_SHL2, FN_SHL4, FN_XCHG: begin
        fl_nx.c   = 1'b0;
        fl_nx.ov0 = 1'b0;
        fl_nx.ov1 = 1'b0;
      end
      FN_SUB, FN_ADD, FN_SBB, FN_ADC, FN_DEC, FN_INC: begin
        if (ctl.fn[0]) begin  // add family
          fl_nx.c = (alu_r < alu_q);
          ovf     = (alu_q[15] ^ alu_r[15]) & ~(alu_q[15] ^ alu_p[15]);
        end else begin
          fl_nx.c = (alu_r > alu_q);
          ovf     = (alu_q[15] ^ alu_r[15]) & (alu_q[15] ^ alu_p[15]);
        end
        fl_nx.ov0 = ovf;
        if (ovf) begin
          fl_nx.s1  = fl[ctl.acc].ov1 ^ ~alu_r[15];
          fl_nx.ov1 = ~fl[ctl.acc].ov1;
        end
      end
      FN_SHR1: begin
        fl_nx.c   = alu_q[0];
        fl_nx.ov0 = 1'b0;
        fl_nx.ov1 = 1'b0;
      end
      FN_SHL1: begin
        fl_nx.c   = alu_q[15];
        fl_nx.ov0 = 1'b0;
        fl_nx.ov1 = 1'b0;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // accumulators and flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RST) begin
      acc_reg[0] <= '0;
      acc_reg[1] <= '0;
      fl[0]      <= '0;
      fl[1]      <= '0;
      r_skip     <= 1'b0;
    end else begin
      case (state)
        ST_STORE: begin
          if (acc_wr_a) acc_reg[0] <= idb;
          if (acc_wr_b) acc_reg[1] <= idb;
          r_skip <= ctl.acc ? acc_wr_b : acc_wr_a;
          if (ctl.active) fl[ctl.acc] <= fl_nx;
        end
        ST_NEXT: begin
          if (ctl.active && ctl.fn != FN_NOP && !r_skip) begin
            acc_reg[ctl.acc] <= alu_r;
          end
        end
        default: ;
      endcase
    end
  end

  assign acc_a   = acc_reg[0];
  assign acc_b   = acc_reg[1];
  assign flags_a = fl[0];
  assign flags_b = fl[1];

endmodule

// ==== dsp_sequencer.sv ====
`timescale 1ns/10ps

module dsp_sequencer #(
  parameter int PGM_ADDR_W = 11
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  dsp_pkg::insn_t        insn,
  output logic [PGM_ADDR_W-1:0] pc,
  output dsp_pkg::exec_state_e  state,
  output dsp_pkg::alu_ctl_t     alu,
  output dsp_pkg::word_t        idb,
  output logic                  acc_wr_a,
  output logic                  acc_wr_b,
  input  dsp_pkg::word_t        acc_a,
  input  dsp_pkg::word_t        acc_b,
  input  dsp_pkg::flags_t       flags_a,
  input  dsp_pkg::flags_t       flags_b,
  input  dsp_pkg::word_t        dr,
  input  dsp_pkg::word_t        sr,
  output logic                  dr_load,
  output logic                  sr_load,
  output logic                  rqm_set,
  output dsp_pkg::word_t        dr_in,
  output dsp_pkg::word_t        sr_in
);
  import dsp_pkg::*;

  insn_t                 op_q;
  insn_class_e           cls;
  reg_sel_e              src_sel;
  reg_sel_e              dst_sel;
  logic [8:0]            jp_brch;
  logic [PGM_ADDR_W-1:0] jp_na;
  word_t                 ld_id;
  logic                  is_alu;
  logic                  dst_wr;
  word_t                 src_word;
  word_t                 tr;
  word_t                 trb;
  flags_t                jf;
  logic                  cond;
  logic                  cond_true;

  // field decode from the latched word
  assign cls     = insn_class_e'(op_q[23:22]);
  assign src_sel = reg_sel_e'(op_q[7:4]);
  assign dst_sel = reg_sel_e'(op_q[3:0]);  // same spot for OP and LD
  assign jp_brch = op_q[21:13];
  assign jp_na   = PGM_ADDR_W'(op_q[12:2]);
  assign ld_id   = op_q[21:6];
  assign is_alu  = (cls == I_OP) || (cls == I_RT);  // RT runs as OP
  assign dst_wr  = (state == ST_STORE) && (cls != I_JP);

  assign alu = '{fn: alu_fn_e'(op_q[19:16]), acc: op_q[15],
                 p_sel: p_sel_e'(op_q[21:20]), active: is_alu};

  always_comb begin
    case (src_sel)
      REG_ACA: src_word = acc_a;
      REG_ACB: src_word = acc_b;
      REG_TR:  src_word = tr;
      REG_TRB: src_word = trb;
      REG_DR:  src_word = dr;
      REG_SR:  src_word = sr;
      default: src_word = '0;
    endcase
  end

  // jump condition, call treated as plain jump
  always_comb begin
    jf   = jp_brch[2] ? flags_b : flags_a;
    cond = 1'b0;
    if (jp_brch[8:7] == 2'b10 && jp_brch[5:0] == '0) begin
      cond = 1'b1;
    end else if (jp_brch[8:6] == 3'b010 && !jp_brch[0]) begin
      case (jp_brch[5:3])
        3'd0:    cond = (jf.c == jp_brch[1]);
        3'd1:    cond = (jf.z == jp_brch[1]);
        3'd2:    cond = (jf.ov0 == jp_brch[1]);
        3'd3:    cond = (jf.ov1 == jp_brch[1]);
        3'd4:    cond = (jf.s0 == jp_brch[1]);
        3'd5:    cond = (jf.s1 == jp_brch[1]);
        3'd7:    cond = jp_brch[2] && (sr[SR_RQM] == jp_brch[1]);
        default: cond = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // execute FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RST) begin
      state     <= ST_IDLE1;
      pc        <= '0;
      op_q      <= '0;
      idb       <= '0;
      tr        <= '0;
      trb       <= '0;
      cond_true <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          state <= ST_LOAD;
          op_q  <= insn;
        end
        ST_LOAD: begin
          state <= ST_ALU1;
          if (cls == I_LD) idb <= ld_id;
          else if (is_alu) idb <= src_word;
        end
        ST_ALU1: state <= ST_ALU2;
        ST_ALU2: state <= ST_STORE;
        ST_STORE: begin
          state <= ST_NEXT;
          if (dst_wr && dst_sel == REG_TR) tr <= idb;
          if (dst_wr && dst_sel == REG_TRB) trb <= idb;
          cond_true <= cond;
        end
        ST_NEXT: begin
          state <= ST_IDLE1;
          if (cls == I_JP && cond_true) pc <= jp_na;
          else pc <= pc + PGM_ADDR_W'(1);
        end
        ST_IDLE1: state <= ST_IDLE2;
        ST_IDLE2: state <= ST_FETCH;
        default:  state <= ST_IDLE1;
      endcase
    end
  end

  assign acc_wr_a = dst_wr && (dst_sel == REG_ACA);
  assign acc_wr_b = dst_wr && (dst_sel == REG_ACB);
  assign dr_load  = dst_wr && (dst_sel == REG_DR);
  assign sr_load  = dst_wr && (dst_sel == REG_SR);
  // any DR touch raises the host request
  assign rqm_set  = dr_load || ((state == ST_STORE) && is_alu && (src_sel == REG_DR));
  assign dr_in    = idb;
  assign sr_in    = idb;  // masked by the host port

endmodule

// ==== dsp_core_top.sv ====
`timescale 1ns/10ps

module dsp_core_top #(
  parameter int PGM_ADDR_W = 11
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  dsp_pkg::host_bus_t    host,
  output dsp_pkg::byte_t        do_byte,
  input  dsp_pkg::pgm_load_t    load,
  output logic [PGM_ADDR_W-1:0] pc,
  output dsp_pkg::word_t        sr
);
  import dsp_pkg::*;

  insn_t       insn;
  exec_state_e state;
  alu_ctl_t    alu_ctl;
  word_t       idb;
  word_t       acc_a;
  word_t       acc_b;
  flags_t      flags_a;
  flags_t      flags_b;
  word_t       dr;
  word_t       dr_in;
  word_t       sr_in;
  logic        acc_wr_a;
  logic        acc_wr_b;
  logic        dr_load;
  logic        sr_load;
  logic        rqm_set;

  dsp_program_rom #(.PGM_ADDR_W(PGM_ADDR_W)) u_rom (
    .CLK     (CLK),
    .load    (load),
    .rd_addr (pc),
    .rd_data (insn)
  );

  dsp_host_port u_host (
    .CLK     (CLK),
    .RST     (RST),
    .bus     (host),
    .do_byte (do_byte),
    .dr_load (dr_load),
    .sr_load (sr_load),
    .rqm_set (rqm_set),
    .dr_in   (dr_in),
    .sr_in   (sr_in),
    .dr      (dr),
    .sr      (sr)
  );

  dsp_alu u_alu (
    .CLK      (CLK),
    .RST      (RST),
    .state    (state),
    .ctl      (alu_ctl),
    .idb      (idb),
    .acc_wr_a (acc_wr_a),
    .acc_wr_b (acc_wr_b),
    .acc_a    (acc_a),
    .acc_b    (acc_b),
    .flags_a  (flags_a),
    .flags_b  (flags_b)
  );

  dsp_sequencer #(.PGM_ADDR_W(PGM_ADDR_W)) u_seq (
    .CLK      (CLK),
    .RST      (RST),
    .insn     (insn),
    .pc       (pc),
    .state    (state),
    .alu      (alu_ctl),
    .idb      (idb),
    .acc_wr_a (acc_wr_a),
    .acc_wr_b (acc_wr_b),
    .acc_a    (acc_a),
    .acc_b    (acc_b),
    .flags_a  (flags_a),
    .flags_b  (flags_b),
    .dr       (dr),
    .sr       (sr),
    .dr_load  (dr_load),
    .sr_load  (sr_load),
    .rqm_set  (rqm_set),
    .dr_in    (dr_in),
    .sr_in    (sr_in)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD = 2,
  parameter int RST_CYCLES  = 16
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  initial begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

// ==== tb_dsp_core_assert.sv ====
`timescale 1ns/10ps

module tb_dsp_core_assert (
  input logic                 CLK,
  input logic                 RST,
  input dsp_pkg::exec_state_e state,
  input dsp_pkg::word_t       sr,
  input logic                 rqm_set,
  input logic                 data_acc
);
  import dsp_pkg::*;

  int         fail_cnt = 0;
  logic [7:0] st_bits;

  assign st_bits = state;

  //////////////////////////////////////////////////////////////////////
  // host handshake
  //////////////////////////////////////////////////////////////////////

  a_reset_clear : assert property (
    @(posedge CLK) RST |=> (!sr[SR_RQM] && !sr[SR_DRS])
  ) else begin
    fail_cnt++;
    $error("RQM or DRS not clear after reset");
  end

  // drs only moves on a data byte
  a_drs_on_access : assert property (
    @(posedge CLK) disable iff (RST) $changed(sr[SR_DRS]) |-> $past(data_acc)
  ) else begin
    fail_cnt++;
    $error("DRS changed without a recognized host data access");
  end

  a_rqm_on_dr : assert property (
    @(posedge CLK) disable iff (RST) $rose(sr[SR_RQM]) |-> $past(rqm_set)
  ) else begin
    fail_cnt++;
    $error("RQM rose without an instruction touching DR");
  end

  //////////////////////////////////////////////////////////////////////
  // execute sequence
  //////////////////////////////////////////////////////////////////////

  // one-hot rotates left by one each cycle
  a_state_order : assert property (
    @(posedge CLK) disable iff (RST)
      1'b1 |=> st_bits == {$past(st_bits[6:0]), $past(st_bits[7])}
  ) else begin
    fail_cnt++;
    $error("execute state left the fixed order of eight");
  end

endmodule

// ==== tb_dsp_core.sv ====
`timescale 1ns/10ps

module tb_dsp_core;
  import dsp_pkg::*;

  localparam int PROG_LEN  = 16;
  localparam int HOST_ACC  = 40;
  localparam int MAX_POLLS = 20;
  // reset + straight-line program + host accesses + slack
  localparam int CYCLE_LIMIT = 16 + 8 * PROG_LEN + HOST_ACC * 18 + 200;

  localparam logic [8:0] JP_ALWAYS = 9'h100;
  localparam logic [8:0] JP_ZA_1   = 9'h08a;
  localparam logic [8:0] JP_RQM_1  = 9'h0be;

  logic      CLK;
  logic      RST;
  host_bus_t host;
  byte_t     do_byte;
  pgm_load_t load;
  logic [10:0] pc;
  word_t     sr;

  insn_t prog [PROG_LEN];
  int    errors = 0;
  int    cycles = 0;
  int    seed;
  word_t x_val;
  word_t y_val;
  word_t d5_val;
  word_t sum;
  byte_t rd_b;

  tb_clock_gen u_clk (
    .CLK (CLK),
    .RST (RST)
  );

  dsp_core_top #(.PGM_ADDR_W(11)) dut (
    .CLK     (CLK),
    .RST     (RST),
    .host    (host),
    .do_byte (do_byte),
    .load    (load),
    .pc      (pc),
    .sr      (sr)
  );

  bind dsp_core_top tb_dsp_core_assert u_chk (
    .CLK      (CLK),
    .RST      (RST),
    .state    (state),
    .sr       (sr),
    .rqm_set  (rqm_set),
    .data_acc (u_host.data_acc)
  );

  //////////////////////////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic insn_t enc_op(alu_fn_e fn, logic acc, p_sel_e p,
                                   reg_sel_e src, reg_sel_e dst);
    insn_t w;
    w        = '0;
    w[23:22] = I_OP;
    w[21:20] = p;
    w[19:16] = fn;
    w[15]    = acc;
    w[7:4]   = src;
    w[3:0]   = dst;
    return w;
  endfunction

  function automatic insn_t enc_ld(word_t imm, reg_sel_e dst);
    insn_t w;
    w        = '0;
    w[23:22] = I_LD;
    w[21:6]  = imm;
    w[3:0]   = dst;
    return w;
  endfunction

  function automatic insn_t enc_jp(logic [8:0] brch, logic [10:0] target);
    insn_t w;
    w        = '0;
    w[23:22] = I_JP;
    w[21:13] = brch;
    w[12:2]  = target;
    return w;
  endfunction

  function automatic host_bus_t bus_word(logic cs_n, logic rd_n, logic wr_n,
                                         logic a0, byte_t di);
    host_bus_t b;
    b.cs_n = cs_n;
    b.rd_n = rd_n;
    b.wr_n = wr_n;
    b.a0   = a0;
    b.di   = di;
    return b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // host bus tasks
  //////////////////////////////////////////////////////////////////////

  // strobe low for 8 cycles, then 10 idle; data held through recognition
  task automatic host_access(input logic rd, input logic a0, input byte_t wdata,
                             output byte_t rdata);
    @(posedge CLK);
    host <= bus_word(1'b0, !rd, rd, a0, wdata);
    repeat (7) @(posedge CLK);
    @(negedge CLK);
    rdata = do_byte;  // sampled late in the strobe
    @(posedge CLK);
    host <= bus_word(1'b1, 1'b1, 1'b1, a0, wdata);
    repeat (10) @(posedge CLK);
  endtask

  task automatic wait_rqm();
    byte_t st;
    int    n;
    st = '0;
    n  = 0;
    while (!st[7] && n < MAX_POLLS) begin
      host_access(1'b1, 1'b1, 8'h00, st);
      n++;
    end
    if (!st[7]) begin
      $display("RQM was not raised by the program after %0d status reads", n);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t got);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [10:0] exp,
                            input logic [10:0] got);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed   = 80074;
    x_val  = 16'($random(seed));
    y_val  = 16'($random(seed));
    d5_val = 16'($random(seed));
    sum    = x_val + y_val;

    prog[0]  = enc_op(FN_SUB, 1'b0, P_IDB, REG_ACA, REG_NON);  // A - A
    prog[1]  = enc_jp(JP_ZA_1, 11'd4);
    prog[2]  = enc_ld(16'h2222, REG_DR);  // wrong path
    prog[3]  = enc_jp(JP_ALWAYS, 11'd5);
    prog[4]  = enc_ld(16'h1111, REG_DR);
    prog[5]  = enc_jp(JP_RQM_1, 11'd5);
    prog[6]  = enc_ld(y_val, REG_ACB);
    prog[7]  = enc_op(FN_NOP, 1'b0, P_RAM, REG_DR, REG_NON);   // ready for host write
    prog[8]  = enc_jp(JP_RQM_1, 11'd8);
    prog[9]  = enc_op(FN_NOP, 1'b0, P_RAM, REG_DR, REG_ACA);
    prog[10] = enc_op(FN_ADD, 1'b0, P_IDB, REG_ACB, REG_NON);
    prog[11] = enc_op(FN_NOP, 1'b0, P_RAM, REG_ACA, REG_DR);
    prog[12] = enc_jp(JP_RQM_1, 11'd12);
    prog[13] = enc_ld(16'h0400, REG_SR);  // DRC on
    prog[14] = enc_ld(d5_val, REG_DR);
    prog[15] = enc_jp(JP_ALWAYS, 11'd15);

    host <= bus_word(1'b1, 1'b1, 1'b1, 1'b0, 8'h00);
    load <= '{wr: 1'b1, addr: 11'd0, data: prog[0]};
    for (int i = 1; i < PROG_LEN; i++) begin
      @(posedge CLK);
      load <= '{wr: 1'b1, addr: 11'(i), data: prog[i]};
    end
    @(posedge CLK);
    load <= '0;
    while (RST) @(posedge CLK);
    @(negedge CLK);
    check_addr("pc", 11'd0, pc);

    // reset state of SR
    host_access(1'b1, 1'b1, 8'h00, rd_b);
    check_byte("sr_hi", 8'h00, rd_b);

    // flag jump, then the 16-bit read order
    wait_rqm();
    host_access(1'b1, 1'b0, 8'h00, rd_b);
    check_byte("dr_lo", 8'h11, rd_b);
    host_access(1'b1, 1'b0, 8'h00, rd_b);
    check_byte("dr_hi", 8'h11, rd_b);
    @(negedge CLK);
    check_bit("rqm", 1'b0, sr[SR_RQM]);

    // host writes X, program adds Y
    wait_rqm();
    host_access(1'b0, 1'b0, x_val[7:0], rd_b);
    host_access(1'b0, 1'b0, x_val[15:8], rd_b);
    wait_rqm();
    host_access(1'b1, 1'b0, 8'h00, rd_b);
    check_byte("sum_lo", sum[7:0], rd_b);
    host_access(1'b1, 1'b0, 8'h00, rd_b);
    check_byte("sum_hi", sum[15:8], rd_b);

    // 8-bit mode
    wait_rqm();
    host_access(1'b1, 1'b0, 8'h00, rd_b);
    check_byte("dr_8bit", d5_val[7:0], rd_b);
    @(negedge CLK);
    check_bit("rqm", 1'b0, sr[SR_RQM]);
    check_bit("drs", 1'b0, sr[SR_DRS]);
    host_access(1'b1, 1'b1, 8'h00, rd_b);
    check_byte("sr_hi", 8'h04, rd_b);

    // program parks on its last jump
    @(negedge CLK);
    check_addr("pc", 11'd15, pc);

    $display("errors: %0d data checks, %0d assertions", errors, dut.u_chk.fail_cnt);
    if (errors == 0 && dut.u_chk.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

// ==== list.f ====
dsp_pkg.sv
dsp_program_rom.sv
dsp_host_port.sv
dsp_alu.sv
dsp_sequencer.sv
dsp_core_top.sv
tb_clock_gen.sv
tb_dsp_core_assert.sv
tb_dsp_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dsp_core
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
